/* hdl/load_unit_consts.svh */
`ifndef LOAD_UNIT_CONSTS_SVH
`define LOAD_UNIT_CONSTS_SVH

// ----------------------------------------------------------------------
// data path widths
// ----------------------------------------------------------------------

// one integer register, RV64
`define LU_XLEN 64
// Sv39 virtual address
`define LU_VLEN 39
// physical address as seen by the data cache
`define LU_PLEN 56

// ----------------------------------------------------------------------
// data cache and scoreboard widths
// ----------------------------------------------------------------------

// the cache index is exactly the 4 KiB page offset, so it needs no translation
`define LU_INDEX_W 12
// the tag covers the physical address bits above the index
`define LU_TAG_W 44
// id used by the scoreboard to match the result to its instruction
`define LU_TRANS_ID_W 3

`endif

/* hdl/load_unit_pkg.sv */
`default_nettype none

`include "load_unit_consts.svh"

package load_unit_pkg;

    // ----------------------------------------------------------------------
    // plain vectors with a meaning
    // ----------------------------------------------------------------------
    typedef logic [`LU_XLEN-1:0]       xlen_t;
    typedef logic [`LU_VLEN-1:0]       vaddr_t;
    typedef logic [`LU_PLEN-1:0]       paddr_t;
    typedef logic [`LU_TRANS_ID_W-1:0] trans_id_t;
    typedef logic [`LU_XLEN/8-1:0]     be_t;
    typedef logic [2:0]                byte_off_t;
    typedef logic [`LU_INDEX_W-1:0]    dc_index_t;
    typedef logic [`LU_TAG_W-1:0]      dc_tag_t;

    // integer load flavours, the U variants zero extend
    typedef enum logic [2:0] {LD, LW, LWU, LH, LHU, LB, LBU} load_op_e;

    // ----------------------------------------------------------------------
    // structs that travel between units
    // ----------------------------------------------------------------------

    // incoming load request, held by the issue stage until it is popped
    typedef struct packed {
        vaddr_t    vaddr;
        trans_id_t trans_id;
        be_t       be;
        load_op_e  op;
    } load_ctrl_t;

    typedef struct packed {
        logic  valid;
        xlen_t cause;
        xlen_t tval;
    } load_ex_t;

    // request towards the data cache, the index goes first and the tag follows
    typedef struct packed {
        logic      data_req;
        dc_index_t address_index;
        dc_tag_t   address_tag;
        be_t       data_be;
        logic [1:0] data_size;
        logic      kill_req;
        logic      tag_valid;
    } dcache_req_t;

    typedef struct packed {
        logic  data_gnt;
        logic  data_rvalid;
        xlen_t data_rdata;
    } dcache_rsp_t;

    // what has to be remembered about the single outstanding load
    typedef struct packed {
        trans_id_t trans_id;
        byte_off_t byte_off;
        load_op_e  op;
    } load_entry_t;

    // retire decisions taken by the request FSM, consumed by the formatter
    typedef struct packed {
        logic capture;
        logic data_valid;
        logic ex_valid;
        logic ex_from_input;
    } retire_ctrl_t;

    // size code for the cache: byte 0, half 1, word 2, double 3
    function automatic logic [1:0] transfer_size(load_op_e op);
        case (op)
            LD:       return 2'b11;
            LW, LWU:  return 2'b10;
            LH, LHU:  return 2'b01;
            default:  return 2'b00;
        endcase
    endfunction

endpackage

`default_nettype wire

/* hdl/load_request_fsm.sv */
`default_nettype none

`include "load_unit_consts.svh"

module load_request_fsm import load_unit_pkg::*; (
    input  wire logic         clk_i,
    input  wire logic         rst_ni,
    input  wire logic         flush_i,
    input  wire logic         valid_i,
    input  load_ctrl_t        load_ctrl_i,
    input  paddr_t            paddr_i,
    input  wire logic         ex_valid_i,
    input  wire logic         dtlb_hit_i,
    input  wire logic         page_offset_matches_i,
    input  dcache_rsp_t       dcache_rsp_i,
    output dcache_req_t       dcache_req_o,
    output logic              translation_req_o,
    output logic              pop_ld_o,
    output retire_ctrl_t      retire_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } lu_state_e;

    lu_state_e state_d, state_q;

    // ----------------------------------------------------------------------
    // request control
    // ----------------------------------------------------------------------
    always_comb begin : p_request
        state_d           = state_q;
        translation_req_o = 1'b0;
        pop_ld_o          = 1'b0;

        // the index is untranslated, so it can go out with the request
        dcache_req_o.address_index = load_ctrl_i.vaddr[`LU_INDEX_W-1:0];
        // the tag comes from the translation answered in the grant cycle
        dcache_req_o.address_tag   = paddr_i[`LU_INDEX_W+`LU_TAG_W-1:`LU_INDEX_W];
        dcache_req_o.data_be       = load_ctrl_i.be;
        dcache_req_o.data_size     = transfer_size(load_ctrl_i.op);
        dcache_req_o.data_req      = 1'b0;
        dcache_req_o.kill_req      = 1'b0;
        dcache_req_o.tag_valid     = 1'b0;

        case (state_q)
            // SEND_TAG finishes the previous load and can start the next one
            // in the same cycle, so both states share the start path
            IDLE, SEND_TAG: begin
                if (state_q == SEND_TAG) begin
                    dcache_req_o.tag_valid = 1'b1;
                    // an exception in the tag cycle cancels the outstanding access
                    dcache_req_o.kill_req  = ex_valid_i;
                    state_d                = IDLE;
                end
                if (valid_i) begin
                    // translation starts before the store check has settled
                    translation_req_o = 1'b1;
                    if (page_offset_matches_i) begin
                        // a pending store may alias this load, hold off the cache
                        state_d = WAIT_PAGE_OFFSET;
                    end else begin
                        dcache_req_o.data_req = 1'b1;
                        if (!dcache_rsp_i.data_gnt) begin
                            state_d = WAIT_GNT;
                        end else if (dtlb_hit_i) begin
                            // tag goes out in the next cycle
                            state_d  = SEND_TAG;
                            pop_ld_o = 1'b1;
                        end else begin
                            state_d = ABORT_TRANSACTION;
                        end
                    end
                end
            end

            WAIT_PAGE_OFFSET: begin
                // request again once the store no longer matches
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end

            WAIT_GNT: begin
                translation_req_o     = 1'b1;
                dcache_req_o.data_req = 1'b1;
                if (dcache_rsp_i.data_gnt) begin
                    if (dtlb_hit_i) begin
                        state_d  = SEND_TAG;
                        pop_ld_o = 1'b1;
                    end else begin
                        state_d = ABORT_TRANSACTION;
                    end
                end
            end

            // the index was granted but no tag exists yet, so release the
            // cache so that the page table walker can get through
            ABORT_TRANSACTION: begin
                dcache_req_o.kill_req  = 1'b1;
                dcache_req_o.tag_valid = 1'b1;
                state_d                = WAIT_TRANSLATION;
            end

            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            WAIT_FLUSH: begin
                // kill whatever may still be pending in the cache
                dcache_req_o.kill_req  = 1'b1;
                dcache_req_o.tag_valid = 1'b1;
                state_d                = IDLE;
            end

            default: state_d = IDLE;
        endcase

        // a request that carries an exception never reaches the cache.
        // an rvalid in this cycle wins and the exception retires later
        if (valid_i && ex_valid_i) begin
            state_d = IDLE;
            if (!dcache_rsp_i.data_rvalid) begin
                pop_ld_o = 1'b1;
            end
        end

        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // ----------------------------------------------------------------------
    // retire decisions
    // ----------------------------------------------------------------------
    always_comb begin : p_retire
        retire_o.capture       = pop_ld_o && !ex_valid_i;
        retire_o.ex_from_input = valid_i && ex_valid_i && !dcache_rsp_i.data_rvalid;
        // responses during a flush or a kill belong to a cancelled load
        retire_o.data_valid    = dcache_rsp_i.data_rvalid && (state_q != WAIT_FLUSH) &&
                                 !dcache_req_o.kill_req;
        // the exception of the outstanding load shows up in its tag cycle
        retire_o.ex_valid      = retire_o.ex_from_input ||
                                 (dcache_rsp_i.data_rvalid && ex_valid_i &&
                                  (state_q == SEND_TAG));
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a load leaves the issue stage only while the issue stage still offers it,
    // and only with a granted, translated access or as an exception
    a_pop_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_ld_o |-> valid_i && ((dcache_rsp_i.data_gnt && dtlb_hit_i) || ex_valid_i))
        else $error("load popped without a request, or without grant and TLB hit");

endmodule

`default_nettype wire

/* hdl/load_result_format.sv */
`default_nettype none

`include "load_unit_consts.svh"

module load_result_format import load_unit_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  load_ctrl_t    load_ctrl_i,
    input  retire_ctrl_t  retire_i,
    input  xlen_t         rdata_i,
    output logic          valid_o,
    output logic          ex_valid_o,
    output trans_id_t     trans_id_o,
    output xlen_t         result_o
);

    load_entry_t entry_q;
    byte_off_t   off_in;
    byte_off_t   sign_idx_d, sign_idx_q;
    logic        signed_d, signed_q;
    logic [`LU_XLEN/8-1:0] sign_bits;
    logic        sign_bit;
    xlen_t       shifted_data;

    assign off_in = load_ctrl_i.vaddr[2:0];

    // ----------------------------------------------------------------------
    // entry capture and early sign selection
    // ----------------------------------------------------------------------

    // the byte holding the sign is known at pop time, so only a single
    // bit mux remains behind the cache read data
    assign signed_d   = load_ctrl_i.op inside {LW, LH, LB};
    assign sign_idx_d = (load_ctrl_i.op inside {LW, LWU}) ? byte_off_t'(off_in + 3'd3) :
                        (load_ctrl_i.op inside {LH, LHU}) ? byte_off_t'(off_in + 3'd1) :
                                                            off_in;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            entry_q    <= '0;
            sign_idx_q <= '0;
            signed_q   <= 1'b0;
        end else if (retire_i.capture) begin
            entry_q    <= '{trans_id: load_ctrl_i.trans_id, byte_off: off_in, op: load_ctrl_i.op};
            sign_idx_q <= sign_idx_d;
            signed_q   <= signed_d;
        end
    end

    // ----------------------------------------------------------------------
    // realignment and extension
    // ----------------------------------------------------------------------
    assign shifted_data = rdata_i >> {entry_q.byte_off, 3'b000};

    // top bit of every byte lane, one of these is the sign
    for (genvar i = 0; i < `LU_XLEN/8; i++) begin : gen_sign_bits
        assign sign_bits[i] = rdata_i[(i+1)*8-1];
    end

    // forced to zero for the unsigned loads
    assign sign_bit = signed_q & sign_bits[sign_idx_q];

    always_comb begin
        unique case (entry_q.op)
            LW, LWU: result_o = {{(`LU_XLEN-32){sign_bit}}, shifted_data[31:0]};
            LH, LHU: result_o = {{(`LU_XLEN-16){sign_bit}}, shifted_data[15:0]};
            LB, LBU: result_o = {{(`LU_XLEN-8){sign_bit}}, shifted_data[7:0]};
            default: result_o = shifted_data;
        endcase
    end

    // ----------------------------------------------------------------------
    // retire outputs
    // ----------------------------------------------------------------------
    assign valid_o    = retire_i.data_valid | retire_i.ex_valid;
    assign ex_valid_o = retire_i.ex_valid;
    // an exception on the incoming request carries its own id
    assign trans_id_o = retire_i.ex_from_input ? load_ctrl_i.trans_id : entry_q.trans_id;

    // misaligned accesses must have been trapped before they got here
    a_word_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retire_i.capture && (load_ctrl_i.op inside {LW, LWU}) |-> off_in < 3'd5)
        else $error("word load crosses the data word");
    a_half_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retire_i.capture && (load_ctrl_i.op inside {LH, LHU}) |-> off_in < 3'd7)
        else $error("half load crosses the data word");
    a_double_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retire_i.capture && (load_ctrl_i.op == LD) |-> off_in == 3'd0)
        else $error("double load is not aligned");

endmodule

`default_nettype wire

/* hdl/load_unit.sv */
`default_nettype none

module load_unit import load_unit_pkg::*; (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire logic     flush_i,
    // request from issue
    input  wire logic     valid_i,
    input  load_ctrl_t    load_ctrl_i,
    output logic          pop_ld_o,
    // result towards writeback
    output logic          valid_o,
    output trans_id_t     trans_id_o,
    output xlen_t         result_o,
    output load_ex_t      ex_o,
    // address translation
    output logic          translation_req_o,
    output vaddr_t        vaddr_o,
    input  paddr_t        paddr_i,
    input  load_ex_t      ex_i,
    input  wire logic     dtlb_hit_i,
    // store alias check
    input  wire logic     page_offset_matches_i,
    // data cache
    input  dcache_rsp_t   dcache_rsp_i,
    output dcache_req_t   dcache_req_o
);

    retire_ctrl_t retire;

    // the translator sees the request address directly
    assign vaddr_o = load_ctrl_i.vaddr;

    // cause and tval pass straight through, only valid is decided here
    assign ex_o.cause = ex_i.cause;
    assign ex_o.tval  = ex_i.tval;

    load_request_fsm u_request_fsm (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .load_ctrl_i           (load_ctrl_i),
        .paddr_i               (paddr_i),
        .ex_valid_i            (ex_i.valid),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_matches_i (page_offset_matches_i),
        .dcache_rsp_i          (dcache_rsp_i),
        .dcache_req_o          (dcache_req_o),
        .translation_req_o     (translation_req_o),
        .pop_ld_o              (pop_ld_o),
        .retire_o              (retire)
    );

    load_result_format u_result_format (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_ctrl_i (load_ctrl_i),
        .retire_i    (retire),
        .rdata_i     (dcache_rsp_i.data_rdata),
        .valid_o     (valid_o),
        .ex_valid_o  (ex_o.valid),
        .trans_id_o  (trans_id_o),
        .result_o    (result_o)
    );

endmodule

`default_nettype wire

/* tb/tb_load_unit.sv */
`default_nettype none

module tb_load_unit import load_unit_pkg::*; ();

    // one stimulus row, the expected values follow from op, vaddr and the drawn word
    typedef struct packed {
        load_op_e   op;
        vaddr_t     vaddr;
        trans_id_t  tid;
        be_t        be;
        logic [3:0] gnt_delay;
        logic [3:0] tlb_miss;
        logic [3:0] page_match;
        logic       ex;
        xlen_t      cause;
        logic       flush;
    } row_t;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    logic        valid_i;
    load_ctrl_t  load_ctrl_i;
    logic        pop_ld_o;
    logic        valid_o;
    trans_id_t   trans_id_o;
    xlen_t       result_o;
    load_ex_t    ex_o;
    logic        translation_req_o;
    vaddr_t      vaddr_o;
    paddr_t      paddr_i;
    load_ex_t    ex_i;
    logic        dtlb_hit_i;
    logic        page_offset_matches_i;
    dcache_rsp_t dcache_rsp_i;
    dcache_req_t dcache_req_o;

    row_t        rows[$];
    string       names[$];
    row_t        cur;
    string       cur_name;
    xlen_t       cur_word;
    logic [15:0] lfsr_q;
    logic        popped;
    int          valid_cnt;
    int          kill_cnt;
    int          miss_cnt;
    int          gnt_wait_cnt;
    int          cyc_cnt;
    logic        prev_waiting;
    dc_index_t   prev_index;
    logic        tag_ok;
    logic [1:0]  rv_pipe;
    xlen_t       got_result;
    trans_id_t   got_tid;
    load_ex_t    got_ex;
    int          err_cnt;
    logic        timed_out;

    load_unit dut_i (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .flush_i               (flush_i),
        .valid_i               (valid_i),
        .load_ctrl_i           (load_ctrl_i),
        .pop_ld_o              (pop_ld_o),
        .valid_o               (valid_o),
        .trans_id_o            (trans_id_o),
        .result_o              (result_o),
        .ex_o                  (ex_o),
        .translation_req_o     (translation_req_o),
        .vaddr_o               (vaddr_o),
        .paddr_i               (paddr_i),
        .ex_i                  (ex_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_matches_i (page_offset_matches_i),
        .dcache_rsp_i          (dcache_rsp_i),
        .dcache_req_o          (dcache_req_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // ----------------------------------------------------------------------
    // reference helpers
    // ----------------------------------------------------------------------

    // 16 bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one LFSR step per read data bit
    task automatic draw_word(output xlen_t w);
        w = '0;
        for (int b = 0; b < $bits(xlen_t); b++) begin
            w      = {w[$bits(xlen_t)-2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // the addressed bytes move to the bottom, then sign or zero extension
    function automatic xlen_t extend_load(xlen_t word, load_op_e op, byte_off_t off);
        xlen_t sh;
        sh = word >> (8 * off);
        case (op)
            LW:      return {{32{sh[31]}}, sh[31:0]};
            LWU:     return {32'h0, sh[31:0]};
            LH:      return {{48{sh[15]}}, sh[15:0]};
            LHU:     return {48'h0, sh[15:0]};
            LB:      return {{56{sh[7]}}, sh[7:0]};
            LBU:     return {56'h0, sh[7:0]};
            default: return sh;
        endcase
    endfunction

    // cache size code as the number of bytes in log2
    function automatic logic [1:0] size_code(load_op_e op);
        if (op == LD) return 2'd3;
        if (op == LW || op == LWU) return 2'd2;
        if (op == LH || op == LHU) return 2'd1;
        return 2'd0;
    endfunction

    task automatic report_error(string what);
        $display("ERROR %s: %s", cur_name, what);
        err_cnt++;
    endtask

    task automatic check_data(string name, xlen_t exp, xlen_t act);
        if (act !== exp) begin
            $display("MISMATCH %s result expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_tid(string name, trans_id_t exp, trans_id_t act);
        if (act !== exp) begin
            $display("MISMATCH %s trans_id expected %0d actual %0d", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_ex(string name, load_ex_t exp, load_ex_t act);
        if (act !== exp) begin
            $display("MISMATCH %s exception expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // request fields towards the translator and the cache
    task automatic check_req(string name, string field, logic [63:0] exp, logic [63:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s %s expected %h actual %h", name, field, exp, act);
            err_cnt++;
        end
    endtask

    // ----------------------------------------------------------------------
    // TLB and cache model, sampled mid cycle and driven after the edge
    // ----------------------------------------------------------------------
    task automatic sample_outputs();
        cyc_cnt++;
        if (pop_ld_o) popped = 1'b1;
        if (valid_o) begin
            // a result before the pop belongs to no accepted request
            if (!popped) report_error("result seen without an accepted request");
            valid_cnt++;
            got_result = result_o;
            got_tid    = trans_id_o;
            got_ex     = ex_o;
        end
        if (translation_req_o) begin
            check_req(cur_name, "vaddr", 64'(cur.vaddr), 64'(vaddr_o));
        end
        if (dcache_req_o.data_req) begin
            check_req(cur_name, "index", 64'(cur.vaddr[11:0]),
                      64'(dcache_req_o.address_index));
            check_req(cur_name, "be", 64'(cur.be), 64'(dcache_req_o.data_be));
            check_req(cur_name, "size", 64'(size_code(cur.op)),
                      64'(dcache_req_o.data_size));
        end
        // the physical address equals the virtual one in this TLB model
        if (dcache_req_o.tag_valid && !dcache_req_o.kill_req) begin
            check_req(cur_name, "tag", 64'(cur.vaddr) >> 12, 64'(dcache_req_o.address_tag));
        end
        if (dcache_req_o.kill_req && dcache_req_o.tag_valid) kill_cnt++;
        tag_ok = dcache_req_o.tag_valid && !dcache_req_o.kill_req;
        if (translation_req_o && !dtlb_hit_i) miss_cnt++;
        if (dcache_req_o.data_req && !dcache_rsp_i.data_gnt) gnt_wait_cnt++;
        if (page_offset_matches_i && dcache_req_o.data_req) begin
            report_error("cache request while a store matches the page offset");
        end
        // an ungranted request must hold with the same index
        if (prev_waiting && !cur.flush) begin
            if (!dcache_req_o.data_req) begin
                report_error("cache request dropped before grant");
            end else if (dcache_req_o.address_index !== prev_index) begin
                report_error("cache index changed while waiting for grant");
            end
        end
        prev_waiting = dcache_req_o.data_req && !dcache_rsp_i.data_gnt;
        prev_index   = dcache_req_o.address_index;
    endtask

    task automatic drive_model();
        dcache_rsp_i.data_gnt  = (gnt_wait_cnt >= int'(cur.gnt_delay));
        dtlb_hit_i             = (miss_cnt >= int'(cur.tlb_miss));
        paddr_i                = paddr_t'(load_ctrl_i.vaddr);
        page_offset_matches_i  = (cyc_cnt < int'(cur.page_match));
        // read data comes back two cycles after an unkilled tag
        rv_pipe                = {rv_pipe[0], tag_ok};
        dcache_rsp_i.data_rvalid = rv_pipe[1];
        dcache_rsp_i.data_rdata  = cur_word;
    endtask

    task automatic cycle();
        @(negedge clk_i);
        sample_outputs();
        @(posedge clk_i);
        #1;
        drive_model();
    endtask

    // ----------------------------------------------------------------------
    // stimulus table and test loop
    // ----------------------------------------------------------------------
    task automatic add_row(string name, load_op_e op, vaddr_t va, trans_id_t tid, be_t be,
                           logic [3:0] dly, logic [3:0] miss, logic [3:0] pm,
                           logic ex, xlen_t cause, logic fl);
        rows.push_back('{op: op, vaddr: va, tid: tid, be: be, gnt_delay: dly, tlb_miss: miss,
                         page_match: pm, ex: ex, cause: cause, flush: fl});
        names.push_back(name);
    endtask

    task automatic build_table();
        add_row("ld_aligned", LD, 39'h0_4000_1230, 3'd1, 8'hff, 4'd0, 4'd0, 4'd0, 1'b0, 64'd0, 1'b0);
        add_row("lw_upper", LW, 39'h0_4000_1234, 3'd2, 8'hf0, 4'd0, 4'd0, 4'd0, 1'b0, 64'd0, 1'b0);
        add_row("lwu_gnt_wait", LWU, 39'h0_4000_2460, 3'd3, 8'h0f, 4'd3, 4'd0, 4'd0, 1'b0, 64'd0,
                1'b0);
        add_row("lh_off6", LH, 39'h0_5000_0016, 3'd4, 8'hc0, 4'd0, 4'd0, 4'd0, 1'b0, 64'd0, 1'b0);
        add_row("lhu_tlb_miss", LHU, 39'h0_5000_0021, 3'd5, 8'h06, 4'd0, 4'd2, 4'd0, 1'b0, 64'd0,
                1'b0);
        add_row("lb_page_match", LB, 39'h0_6000_0347, 3'd6, 8'h80, 4'd0, 4'd0, 4'd3, 1'b0, 64'd0,
                1'b0);
        add_row("lbu_off3", LBU, 39'h0_6000_0ab3, 3'd7, 8'h08, 4'd0, 4'd0, 4'd0, 1'b0, 64'd0, 1'b0);
        // load page fault, cause 13
        add_row("lw_page_fault", LW, 39'h0_7000_0008, 3'd0, 8'h0f, 4'd0, 4'd0, 4'd0, 1'b1, 64'd13,
                1'b0);
        add_row("ld_flush", LD, 39'h0_7000_0100, 3'd1, 8'hff, 4'd6, 4'd0, 4'd0, 1'b0, 64'd0, 1'b1);
        add_row("ld_after_flush", LD, 39'h0_7000_0108, 3'd2, 8'hff, 4'd1, 4'd0, 4'd0, 1'b0, 64'd0,
                1'b0);
    endtask

    task automatic run_row(input int i);
        int       n;
        load_ex_t exp_ex;
        cur          = rows[i];
        cur_name     = names[i];
        popped       = 1'b0;
        valid_cnt    = 0;
        kill_cnt     = 0;
        miss_cnt     = 0;
        gnt_wait_cnt = 0;
        cyc_cnt      = 0;
        prev_waiting = 1'b0;
        draw_word(cur_word);
        load_ctrl_i = '{vaddr: cur.vaddr, trans_id: cur.tid, be: cur.be, op: cur.op};
        ex_i        = '0;
        if (cur.ex) ex_i = '{valid: 1'b1, cause: cur.cause, tval: xlen_t'(cur.vaddr)};
        valid_i = 1'b1;
        drive_model();
        if (cur.flush) begin
            // flush while the request is still waiting for its grant
            for (n = 0; n < 200 && gnt_wait_cnt < 2; n++) cycle();
            if (gnt_wait_cnt < 2) begin
                report_error("timed out waiting for the cache request");
                timed_out = 1'b1;
                return;
            end
            flush_i = 1'b1;
            valid_i = 1'b0;
            cycle();
            flush_i = 1'b0;
            for (n = 0; n < 200 && kill_cnt == 0; n++) cycle();
            if (kill_cnt == 0) begin
                report_error("timed out waiting for the kill after flush");
                timed_out = 1'b1;
                return;
            end
            // longer than the cache latency, nothing may retire
            repeat (4) cycle();
            if (valid_cnt != 0) report_error("flushed load still retired");
        end else begin
            for (n = 0; n < 200 && valid_cnt == 0; n++) begin
                cycle();
                if (popped) begin
                    valid_i = 1'b0;
                    ex_i    = '0;
                end
            end
            if (valid_cnt == 0) begin
                report_error("timed out waiting for valid_o");
                timed_out = 1'b1;
                return;
            end
            exp_ex = '{valid: cur.ex, cause: cur.ex ? cur.cause : '0,
                       tval: cur.ex ? xlen_t'(cur.vaddr) : '0};
            if (!cur.ex) begin
                check_data(cur_name, extend_load(cur_word, cur.op, cur.vaddr[2:0]), got_result);
            end
            check_tid(cur_name, cur.tid, got_tid);
            check_ex(cur_name, exp_ex, got_ex);
            if (kill_cnt != ((cur.tlb_miss != 4'd0) ? 1 : 0)) begin
                report_error("wrong number of kill cycles");
            end
        end
    endtask

    initial begin
        int errs_before;
        int failed_tests;
        int run_cnt;
        rst_ni                = 1'b0;
        flush_i               = 1'b0;
        valid_i               = 1'b0;
        load_ctrl_i           = '0;
        paddr_i               = '0;
        ex_i                  = '0;
        dtlb_hit_i            = 1'b0;
        page_offset_matches_i = 1'b0;
        dcache_rsp_i          = '0;
        cur                   = '0;
        lfsr_q                = 16'd45;
        rv_pipe               = '0;
        tag_ok                = 1'b0;
        err_cnt               = 0;
        timed_out             = 1'b0;
        failed_tests          = 0;
        run_cnt               = 0;
        build_table();
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            errs_before = err_cnt;
            run_row(i);
            run_cnt++;
            if (err_cnt != errs_before) begin
                failed_tests++;
                $display("test %s failed", names[i]);
            end else begin
                $display("test %s ok", names[i]);
            end
        end
        $display("%0d tests run, %0d failed, %0d errors", run_cnt, failed_tests, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+hdl
hdl/load_unit_pkg.sv
hdl/load_request_fsm.sv
hdl/load_result_format.sv
hdl/load_unit.sv
tb/tb_load_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the load unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f verilog.f \
    --top-module tb_load_unit -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_load_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict is the pass line in the simulation output
if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
